/* source/csr_config.svh */
`ifndef CSR_CONFIG_SVH
`define CSR_CONFIG_SVH

//======================================================================
// register geometry
//======================================================================

// width of every csr and of the access bus
`define CSR_XLEN        32

// number of registers in the mvu configuration bank
`define CSR_MVU_NREGS   8

//======================================================================
// identification and boot
//======================================================================

`define CSR_HART_ID     32'h0000_0000
`define CSR_MARCHID     32'h0000_0017
// rv32i with mxl set to 32 bits
`define CSR_ISA_CODE    32'h4000_0100
// mtvec comes out of reset pointing here
`define CSR_BOOT_ADDR   32'h0000_0080

//======================================================================
// interrupt bits in mip and mie
//======================================================================

`define CSR_IRQ_MVU     16
// software (3), timer (7), external (11) and mvu (16)
`define CSR_IRQ_MASK    32'h0001_0888

`endif

/* source/csr_pkg.sv */
`default_nettype none

package csr_pkg;

    // every csr address this unit answers to
    typedef enum logic [11:0] {
        CSR_MVENDORID    = 12'hF11,
        CSR_MARCHID      = 12'hF12,
        CSR_MIMPID       = 12'hF13,
        CSR_MHARTID      = 12'hF14,
        CSR_MSTATUS      = 12'h300,
        CSR_MISA         = 12'h301,
        CSR_MIE          = 12'h304,
        CSR_MTVEC        = 12'h305,
        CSR_MEPC         = 12'h341,
        CSR_MCAUSE       = 12'h342,
        CSR_MTVAL        = 12'h343,
        CSR_MIP          = 12'h344,
        CSR_MCYCLE       = 12'hB00,
        CSR_MCYCLEH      = 12'hB80,
        // mvu bank is contiguous so the offset indexes the array
        CSR_MVUWBASEPTR  = 12'h7C0,
        CSR_MVUIBASEPTR  = 12'h7C1,
        CSR_MVUSBASEPTR  = 12'h7C2,
        CSR_MVUBBASEPTR  = 12'h7C3,
        CSR_MVUOBASEPTR  = 12'h7C4,
        CSR_MVUPRECISION = 12'h7C5,
        CSR_MVUQUANT     = 12'h7C6,
        CSR_MVUCOMMAND   = 12'h7C7
    } csr_addr_e;

    typedef enum logic [2:0] {
        CSR_NONE  = 3'd0,
        CSR_WRITE = 3'd1,
        CSR_SET   = 3'd2,
        CSR_CLEAR = 3'd3,
        CSR_MRET  = 3'd4
    } csr_op_e;

    // rv32 mstatus layout, only mie mpie and mpp are kept here
    typedef struct packed {
        logic       sd;
        logic [7:0] wpri3;
        logic       tsr, tw, tvm, mxr, sum, mprv;
        logic [1:0] xs, fs, mpp, wpri2;
        logic       spp, mpie, wpri1, spie, upie, mie, wpri0, sie, uie;
    } mstatus_t;

endpackage

`default_nettype wire

/* source/csr_access_ctrl.sv */
`default_nettype none

`include "csr_config.svh"

module csr_access_ctrl (
    input  wire logic [11:0]            csr_addr_i,
    input  csr_pkg::csr_op_e            csr_op_i,
    input  wire logic [`CSR_XLEN-1:0]   csr_wdata_i,
    // bank responses
    input  wire logic                   machine_hit_i,
    input  wire logic                   mvu_hit_i,
    input  wire logic [`CSR_XLEN-1:0]   machine_rdata_i,
    input  wire logic [`CSR_XLEN-1:0]   mvu_rdata_i,
    // shared access bus
    output csr_pkg::csr_addr_e          bus_addr_o,
    output logic [`CSR_XLEN-1:0]        bus_wdata_o,
    output logic                        bus_we_o,
    output logic                        bus_mret_o,
    // core side
    output logic [`CSR_XLEN-1:0]        csr_rdata_o,
    output logic                        illegal_o
);

    logic                any_hit;
    logic                access;
    logic [`CSR_XLEN-1:0] merged_rdata;

    // address goes out typed so both banks decode the same enum
    assign bus_addr_o = csr_pkg::csr_addr_e'(csr_addr_i);

    // banks drive zero when they miss so a plain or merges them
    assign any_hit      = machine_hit_i | mvu_hit_i;
    assign merged_rdata = machine_rdata_i | mvu_rdata_i;

    //==================================================================
    // operation decode
    //==================================================================
    always_comb begin : op_decode
        access      = 1'b0;
        bus_mret_o  = 1'b0;
        bus_wdata_o = csr_wdata_i;
        case (csr_op_i)
            csr_pkg::CSR_WRITE: begin
                access = 1'b1;
            end
            // set and clear modify the value read in this same cycle
            csr_pkg::CSR_SET: begin
                access      = 1'b1;
                bus_wdata_o = merged_rdata | csr_wdata_i;
            end
            csr_pkg::CSR_CLEAR: begin
                access      = 1'b1;
                bus_wdata_o = merged_rdata & ~csr_wdata_i;
            end
            // mret has no read or write side effect
            csr_pkg::CSR_MRET: bus_mret_o = 1'b1;
            default: ;
        endcase
    end

    // no bank claims the address so the write is dropped
    assign bus_we_o    = access & any_hit;
    assign illegal_o   = access & ~any_hit;
    // old value goes back to the core for every access
    assign csr_rdata_o = access ? merged_rdata : '0;

endmodule

`default_nettype wire

/* source/machine_csr_bank.sv */
`default_nettype none

`include "csr_config.svh"

module machine_csr_bank (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    // shared access bus
    input  csr_pkg::csr_addr_e          bus_addr_i,
    input  wire logic [`CSR_XLEN-1:0]   bus_wdata_i,
    input  wire logic                   bus_we_i,
    input  wire logic                   bus_mret_i,
    // core and mvu side
    input  wire logic                   mvu_irq_i,
    input  wire logic [`CSR_XLEN-1:0]   pc_i,
    input  wire logic [`CSR_XLEN-1:0]   cause_i,
    input  wire logic                   cycle_en_i,
    output logic                        hit_o,
    output logic [`CSR_XLEN-1:0]        rdata_o,
    output logic                        irq_o,
    output logic [`CSR_XLEN-1:0]        trap_target_o
);

    csr_pkg::mstatus_t    mstatus_q, mstatus_d, wr_status;
    logic [`CSR_XLEN-1:0] mie_q, mie_d;
    logic [`CSR_XLEN-1:0] mip_q, mip_d;
    logic [`CSR_XLEN-1:0] mtvec_q, mtvec_d;
    logic [`CSR_XLEN-1:0] mepc_q, mepc_d;
    logic [`CSR_XLEN-1:0] mcause_q, mcause_d;
    logic [`CSR_XLEN-1:0] mtval_q, mtval_d;
    logic [63:0]          mcycle_q, mcycle_d;
    // set while an interrupt is being taken so mepc is loaded once
    logic                 serviced_q, serviced_d;

    assign wr_status = csr_pkg::mstatus_t'(bus_wdata_i);

    // mvu interrupt needs global enable, its own enable and pending
    assign irq_o = mstatus_q.mie & mie_q[`CSR_IRQ_MVU] & mip_q[`CSR_IRQ_MVU];

    // mret jumps back to mepc, otherwise the trap vector
    assign trap_target_o = bus_mret_i ? mepc_q : mtvec_q;

    //==================================================================
    // read decode
    //==================================================================
    always_comb begin : read_decode
        hit_o   = 1'b1;
        rdata_o = '0;
        case (bus_addr_i)
            // vendor and implementation ids read as zero
            csr_pkg::CSR_MVENDORID: rdata_o = '0;
            csr_pkg::CSR_MIMPID:    rdata_o = '0;
            csr_pkg::CSR_MARCHID:   rdata_o = `CSR_MARCHID;
            csr_pkg::CSR_MHARTID:   rdata_o = `CSR_HART_ID;
            csr_pkg::CSR_MISA:      rdata_o = `CSR_ISA_CODE;
            csr_pkg::CSR_MSTATUS:   rdata_o = mstatus_q;
            csr_pkg::CSR_MIE:       rdata_o = mie_q;
            csr_pkg::CSR_MIP:       rdata_o = mip_q;
            csr_pkg::CSR_MTVEC:     rdata_o = mtvec_q;
            csr_pkg::CSR_MEPC:      rdata_o = mepc_q;
            csr_pkg::CSR_MCAUSE:    rdata_o = mcause_q;
            csr_pkg::CSR_MTVAL:     rdata_o = mtval_q;
            csr_pkg::CSR_MCYCLE:    rdata_o = mcycle_q[31:0];
            csr_pkg::CSR_MCYCLEH:   rdata_o = mcycle_q[63:32];
            default:                hit_o   = 1'b0;
        endcase
    end

    //==================================================================
    // next state
    //==================================================================
    always_comb begin : next_state
        mstatus_d  = mstatus_q;
        mie_d      = mie_q;
        mip_d      = mip_q;
        mtvec_d    = mtvec_q;
        mepc_d     = mepc_q;
        mcause_d   = mcause_q;
        mtval_d    = mtval_q;
        mcycle_d   = cycle_en_i ? mcycle_q + 64'd1 : mcycle_q;
        serviced_d = irq_o;

        // software writes with masking, id registers and misa ignore writes
        if (bus_we_i) begin
            case (bus_addr_i)
                csr_pkg::CSR_MSTATUS: begin
                    // everything else including sd reads as zero
                    mstatus_d      = '0;
                    mstatus_d.mie  = wr_status.mie;
                    mstatus_d.mpie = wr_status.mpie;
                    mstatus_d.mpp  = wr_status.mpp;
                end
                csr_pkg::CSR_MIE:    mie_d    = bus_wdata_i & `CSR_IRQ_MASK;
                csr_pkg::CSR_MIP:    mip_d    = bus_wdata_i & `CSR_IRQ_MASK;
                csr_pkg::CSR_MTVEC:  mtvec_d  = bus_wdata_i;
                csr_pkg::CSR_MEPC:   mepc_d   = {bus_wdata_i[`CSR_XLEN-1:1], 1'b0};
                csr_pkg::CSR_MCAUSE: mcause_d = bus_wdata_i;
                csr_pkg::CSR_MTVAL:  mtval_d  = bus_wdata_i;
                default: ;
            endcase
        end

        // sticky pending bit, only a software write to mip clears it
        if (!(bus_we_i && bus_addr_i == csr_pkg::CSR_MIP)) begin
            mip_d[`CSR_IRQ_MVU] = mip_q[`CSR_IRQ_MVU] | mvu_irq_i;
        end

        // trap entry
        if (irq_o) begin
            mcause_d       = {1'b1, {(`CSR_XLEN-6){1'b0}}, cause_i[4:0]};
            mstatus_d.mpie = mstatus_q.mie;
            // first edge of this interrupt
            if (!serviced_q) begin
                mepc_d = pc_i;
            end
        end

        // trap return restores the enable
        if (bus_mret_i) begin
            mstatus_d.mie  = mstatus_q.mpie;
            mstatus_d.mpie = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mstatus_q  <= '0;
            mie_q      <= '0;
            mip_q      <= '0;
            mtvec_q    <= `CSR_BOOT_ADDR;
            mepc_q     <= '0;
            mcause_q   <= '0;
            mtval_q    <= '0;
            mcycle_q   <= '0;
            serviced_q <= 1'b0;
        end else begin
            mstatus_q  <= mstatus_d;
            mie_q      <= mie_d;
            mip_q      <= mip_d;
            mtvec_q    <= mtvec_d;
            mepc_q     <= mepc_d;
            mcause_q   <= mcause_d;
            mtval_q    <= mtval_d;
            mcycle_q   <= mcycle_d;
            serviced_q <= serviced_d;
        end
    end

endmodule

`default_nettype wire

/* source/mvu_csr_bank.sv */
`default_nettype none

`include "csr_config.svh"

module mvu_csr_bank (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    // shared access bus
    input  csr_pkg::csr_addr_e          bus_addr_i,
    input  wire logic [`CSR_XLEN-1:0]   bus_wdata_i,
    input  wire logic                   bus_we_i,
    output logic                        hit_o,
    output logic [`CSR_XLEN-1:0]        rdata_o,
    // accelerator side
    output logic                        mvu_start_o,
    output logic [`CSR_XLEN-1:0]        mvu_regs_o [`CSR_MVU_NREGS]
);

    localparam int IDX_W = $clog2(`CSR_MVU_NREGS);

    logic [11:0]          offset;
    logic [IDX_W-1:0]     idx;
    logic [`CSR_XLEN-1:0] regs_q [`CSR_MVU_NREGS];

    // offset from the first mvu address, a miss wraps to a large value
    assign offset = bus_addr_i - csr_pkg::CSR_MVUWBASEPTR;
    assign idx    = offset[IDX_W-1:0];
    assign hit_o  = (offset < `CSR_MVU_NREGS);

    assign rdata_o = hit_o ? regs_q[idx] : '0;

    // every register is wired straight to the mvu
    assign mvu_regs_o = regs_q;

    //==================================================================
    // register array and start pulse
    //==================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `CSR_MVU_NREGS; i++) begin
                regs_q[i] <= '0;
            end
            mvu_start_o <= 1'b0;
        end else begin
            if (bus_we_i && hit_o) begin
                regs_q[idx] <= bus_wdata_i;
            end
            // one cycle high after each command write
            mvu_start_o <= bus_we_i && (bus_addr_i == csr_pkg::CSR_MVUCOMMAND);
        end
    end

endmodule

`default_nettype wire

/* source/csr_unit_top.sv */
`default_nettype none

`include "csr_config.svh"

module csr_unit_top (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    // csr access from the core
    input  wire logic [11:0]            csr_addr_i,
    input  csr_pkg::csr_op_e            csr_op_i,
    input  wire logic [`CSR_XLEN-1:0]   csr_wdata_i,
    output logic [`CSR_XLEN-1:0]        csr_rdata_o,
    output logic                        illegal_o,
    // interrupt and trap
    input  wire logic                   mvu_irq_i,
    input  wire logic [`CSR_XLEN-1:0]   pc_i,
    input  wire logic [`CSR_XLEN-1:0]   cause_i,
    input  wire logic                   cycle_en_i,
    output logic                        irq_o,
    output logic [`CSR_XLEN-1:0]        trap_target_o,
    // mvu configuration
    output logic                        mvu_start_o,
    output logic [`CSR_XLEN-1:0]        mvu_regs_o [`CSR_MVU_NREGS]
);

    // shared access bus
    csr_pkg::csr_addr_e   bus_addr;
    logic [`CSR_XLEN-1:0] bus_wdata;
    logic                 bus_we;
    logic                 bus_mret;
    // bank responses
    logic                 machine_hit, mvu_hit;
    logic [`CSR_XLEN-1:0] machine_rdata, mvu_rdata;

    csr_access_ctrl u_access_ctrl (
        .csr_addr_i      (csr_addr_i),
        .csr_op_i        (csr_op_i),
        .csr_wdata_i     (csr_wdata_i),
        .machine_hit_i   (machine_hit),
        .mvu_hit_i       (mvu_hit),
        .machine_rdata_i (machine_rdata),
        .mvu_rdata_i     (mvu_rdata),
        .bus_addr_o      (bus_addr),
        .bus_wdata_o     (bus_wdata),
        .bus_we_o        (bus_we),
        .bus_mret_o      (bus_mret),
        .csr_rdata_o     (csr_rdata_o),
        .illegal_o       (illegal_o)
    );

    machine_csr_bank u_machine_bank (
        .clk (clk), .rst_n (rst_n),
        .bus_addr_i (bus_addr), .bus_wdata_i (bus_wdata),
        .bus_we_i (bus_we), .bus_mret_i (bus_mret),
        .mvu_irq_i (mvu_irq_i), .pc_i (pc_i), .cause_i (cause_i),
        .cycle_en_i (cycle_en_i), .hit_o (machine_hit), .rdata_o (machine_rdata),
        .irq_o (irq_o), .trap_target_o (trap_target_o)
    );

    mvu_csr_bank u_mvu_bank (
        .clk (clk), .rst_n (rst_n),
        .bus_addr_i (bus_addr), .bus_wdata_i (bus_wdata), .bus_we_i (bus_we),
        .hit_o (mvu_hit), .rdata_o (mvu_rdata),
        .mvu_start_o (mvu_start_o), .mvu_regs_o (mvu_regs_o)
    );

endmodule

`default_nettype wire

/* test/csr_unit_tests.svh */
// registers read their reset values, outputs idle
task automatic test_reset_values();
    int errs_at_start;
    errs_at_start = errors;
    check_eq("irq_o", irq, 1'b0);
    check_eq("illegal_o", illegal, 1'b0);
    check_eq("mvu_start_o", mvu_start, 1'b0);
    csr_read(csr_pkg::CSR_MHARTID);
    check_eq("mhartid", last_rdata, `CSR_HART_ID);
    csr_read(csr_pkg::CSR_MARCHID);
    check_eq("marchid", last_rdata, `CSR_MARCHID);
    csr_read(csr_pkg::CSR_MISA);
    check_eq("misa", last_rdata, `CSR_ISA_CODE);
    csr_read(csr_pkg::CSR_MTVEC);
    check_eq("mtvec", last_rdata, `CSR_BOOT_ADDR);
    csr_read(csr_pkg::CSR_MCAUSE);
    check_eq("mcause", last_rdata, 32'h0);
    csr_read(csr_pkg::CSR_MEPC);
    check_eq("mepc", last_rdata, 32'h0);
    for (int i = 0; i < `CSR_MVU_NREGS; i++) begin
        csr_read(12'(csr_pkg::CSR_MVUWBASEPTR + i));
        check_eq("mvu register", last_rdata, 32'h0);
        check_eq("mvu_regs_o", mvu_regs[i], 32'h0);
    end
    check_eq("illegal_o", last_illegal, 1'b0);
    report_test("reset values", errs_at_start);
endtask

// write, set, clear, each returns the previous value
task automatic rmw_one(input logic [11:0] addr, input string name,
                       input logic [31:0] old_val, output logic [31:0] new_val);
    logic [31:0] expect_val;
    logic [31:0] wr_val;
    logic [31:0] set_val;
    logic [31:0] clr_val;
    wr_val     = $random(seed);
    set_val    = $random(seed);
    clr_val    = $random(seed);
    expect_val = old_val;
    csr_access(addr, csr_pkg::CSR_WRITE, wr_val);
    check_eq(name, last_rdata, expect_val);
    expect_val = wr_val;
    csr_access(addr, csr_pkg::CSR_SET, set_val);
    check_eq(name, last_rdata, expect_val);
    expect_val = expect_val | set_val;
    csr_access(addr, csr_pkg::CSR_CLEAR, clr_val);
    check_eq(name, last_rdata, expect_val);
    expect_val = expect_val & ~clr_val;
    csr_read(addr);
    check_eq(name, last_rdata, expect_val);
    new_val = expect_val;
endtask

task automatic test_read_modify_write();
    int errs_at_start;
    errs_at_start = errors;
    // wbaseptr, bbaseptr and quant
    for (int idx = 0; idx < `CSR_MVU_NREGS; idx += 3) begin
        rmw_one(12'(csr_pkg::CSR_MVUWBASEPTR + idx), "mvu register",
                mvu_model[idx], mvu_model[idx]);
        check_eq("mvu_regs_o", mvu_regs[idx], mvu_model[idx]);
    end
    rmw_one(csr_pkg::CSR_MTVAL, "mtval", mtval_model, mtval_model);
    report_test("read modify write", errs_at_start);
endtask

task automatic test_write_masking();
    int errs_at_start;
    errs_at_start = errors;
    csr_access(csr_pkg::CSR_MEPC, csr_pkg::CSR_WRITE, 32'hFFFF_FFFF);
    csr_read(csr_pkg::CSR_MEPC);
    check_eq("mepc", last_rdata, 32'hFFFF_FFFE);
    csr_access(csr_pkg::CSR_MIE, csr_pkg::CSR_WRITE, 32'hFFFF_FFFF);
    csr_read(csr_pkg::CSR_MIE);
    check_eq("mie", last_rdata, `CSR_IRQ_MASK);
    // only mpp (12:11), mpie (7) and mie (3) survive
    csr_access(csr_pkg::CSR_MSTATUS, csr_pkg::CSR_WRITE, 32'hFFFF_FFFF);
    csr_read(csr_pkg::CSR_MSTATUS);
    check_eq("mstatus", last_rdata, 32'h0000_1888);
    check_eq("mstatus.sd", last_rdata[31], 1'b0);
    csr_access(csr_pkg::CSR_MISA, csr_pkg::CSR_WRITE, 32'h0);
    csr_read(csr_pkg::CSR_MISA);
    check_eq("misa", last_rdata, `CSR_ISA_CODE);
    // back to a quiet state for the interrupt test
    csr_access(csr_pkg::CSR_MIE, csr_pkg::CSR_WRITE, 32'h0);
    csr_access(csr_pkg::CSR_MSTATUS, csr_pkg::CSR_WRITE, 32'h0);
    report_test("write masking", errs_at_start);
endtask

task automatic test_illegal_and_start();
    int          errs_at_start;
    logic [31:0] data;
    errs_at_start = errors;
    // just past the last mvu register
    csr_access(12'h7C8, csr_pkg::CSR_WRITE, $random(seed));
    check_eq("illegal_o", last_illegal, 1'b1);
    check_eq("mvu_start_o", mvu_start, 1'b0);
    for (int i = 0; i < `CSR_MVU_NREGS; i++) begin
        check_eq("mvu_regs_o", mvu_regs[i], mvu_model[i]);
    end
    csr_read(csr_pkg::CSR_MTVAL);
    check_eq("mtval", last_rdata, mtval_model);
    check_eq("illegal_o", last_illegal, 1'b0);
    data = $random(seed);
    csr_access(csr_pkg::CSR_MVUCOMMAND, csr_pkg::CSR_WRITE, data);
    mvu_model[7] = data;
    // pulse sits in the cycle right after the write edge
    check_eq("mvu_start_o", mvu_start, 1'b1);
    @(negedge clk);
    check_eq("mvu_start_o", mvu_start, 1'b0);
    csr_access(csr_pkg::CSR_MVUPRECISION, csr_pkg::CSR_WRITE, data);
    mvu_model[5] = data;
    check_eq("mvu_start_o", mvu_start, 1'b0);
    check_eq("mvu_regs_o", mvu_regs[5], mvu_model[5]);
    check_eq("mvu_regs_o", mvu_regs[7], mvu_model[7]);
    report_test("illegal access and start pulse", errs_at_start);
endtask

task automatic test_cycle_counter();
    int          errs_at_start;
    logic [31:0] first;
    errs_at_start = errors;
    @(negedge clk);
    cycle_en = 1'b1;
    csr_read(csr_pkg::CSR_MCYCLE);
    first = last_rdata;
    repeat (10) @(negedge clk);
    csr_read(csr_pkg::CSR_MCYCLE);
    // ten idle cycles plus one each from the two reads
    check_eq("mcycle", last_rdata, first + 32'd12);
    @(negedge clk);
    cycle_en = 1'b0;
    csr_read(csr_pkg::CSR_MCYCLE);
    first = last_rdata;
    repeat (10) @(negedge clk);
    csr_read(csr_pkg::CSR_MCYCLE);
    check_eq("mcycle", last_rdata, first);
    report_test("cycle counter", errs_at_start);
endtask

task automatic test_interrupt_return();
    int          errs_at_start;
    logic [31:0] pc_first;
    logic [31:0] cause_val;
    errs_at_start = errors;
    pc_first  = $random(seed) & ~32'h3;
    cause_val = $random(seed);
    @(negedge clk);
    mvu_irq = 1'b1;
    @(negedge clk);
    mvu_irq = 1'b0;
    csr_read(csr_pkg::CSR_MIP);
    check_eq("mip", last_rdata, 32'h1 << `CSR_IRQ_MVU);
    csr_access(csr_pkg::CSR_MIE, csr_pkg::CSR_WRITE, 32'h1 << `CSR_IRQ_MVU);
    check_eq("irq_o", irq, 1'b0);
    pc    = pc_first;
    cause = cause_val;
    // global enable, irq rises after this edge
    csr_access(csr_pkg::CSR_MSTATUS, csr_pkg::CSR_WRITE, 32'h8);
    check_eq("irq_o", irq, 1'b1);
    check_eq("trap_target_o", trap_target, `CSR_BOOT_ADDR);
    // later pc values must not reach mepc
    @(negedge clk);
    pc = pc_first + 32'd4;
    csr_read(csr_pkg::CSR_MCAUSE);
    check_eq("mcause", last_rdata, 32'h8000_0000 | (cause_val & 32'h1F));
    csr_read(csr_pkg::CSR_MEPC);
    check_eq("mepc", last_rdata, pc_first);
    csr_read(csr_pkg::CSR_MSTATUS);
    check_eq("mstatus.mpie", last_rdata[7], 1'b1);
    csr_access(csr_pkg::CSR_MIP, csr_pkg::CSR_WRITE, 32'h0);
    check_eq("irq_o", irq, 1'b0);
    // drop the global enable so only mret can bring it back
    csr_access(csr_pkg::CSR_MSTATUS, csr_pkg::CSR_CLEAR, 32'h8);
    csr_read(csr_pkg::CSR_MSTATUS);
    check_eq("mstatus.mie", last_rdata[3], 1'b0);
    csr_access(csr_pkg::CSR_MSTATUS, csr_pkg::CSR_MRET, 32'h0);
    check_eq("trap_target_o", last_target, pc_first);
    csr_read(csr_pkg::CSR_MSTATUS);
    check_eq("mstatus.mie", last_rdata[3], 1'b1);
    report_test("interrupt and return", errs_at_start);
endtask

/* test/tb_csr_unit.sv */
`default_nettype none

`include "csr_config.svh"

module tb_csr_unit;

    timeunit 1ns;
    timeprecision 1ps;

    // roughly twice the cycles the directed tests need
    localparam int MAX_CYCLES = 400;

    logic                 clk = 1'b0;
    logic                 rst_n;
    logic [11:0]          csr_addr;
    csr_pkg::csr_op_e     csr_op;
    logic [`CSR_XLEN-1:0] csr_wdata;
    logic [`CSR_XLEN-1:0] csr_rdata;
    logic                 illegal;
    logic                 mvu_irq;
    logic [`CSR_XLEN-1:0] pc;
    logic [`CSR_XLEN-1:0] cause;
    logic                 cycle_en;
    logic                 irq;
    logic [`CSR_XLEN-1:0] trap_target;
    logic                 mvu_start;
    logic [`CSR_XLEN-1:0] mvu_regs [`CSR_MVU_NREGS];

    // responses captured just before the rising edge of an access
    logic [`CSR_XLEN-1:0] last_rdata;
    logic                 last_illegal;
    logic [`CSR_XLEN-1:0] last_target;
    // expected register contents
    logic [`CSR_XLEN-1:0] mvu_model [`CSR_MVU_NREGS];
    logic [`CSR_XLEN-1:0] mtval_model;

    integer seed;
    int     cycle_count = 0;
    int     tests_run = 0;
    int     checks = 0;
    int     errors = 0;

    always #20 clk = ~clk;

    csr_unit_top i_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .csr_addr_i    (csr_addr),
        .csr_op_i      (csr_op),
        .csr_wdata_i   (csr_wdata),
        .csr_rdata_o   (csr_rdata),
        .illegal_o     (illegal),
        .mvu_irq_i     (mvu_irq),
        .pc_i          (pc),
        .cause_i       (cause),
        .cycle_en_i    (cycle_en),
        .irq_o         (irq),
        .trap_target_o (trap_target),
        .mvu_start_o   (mvu_start),
        .mvu_regs_o    (mvu_regs)
    );

    //======================================================================
    // helpers
    //======================================================================
    task automatic check_eq(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got 0x%08h expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int errs_at_start);
        tests_run++;
        if (errors == errs_at_start) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - errs_at_start);
        end
    endtask

    // one access cycle, driven on the falling edge, then back to idle
    task automatic csr_access(input logic [11:0] addr, input csr_pkg::csr_op_e op,
                              input logic [31:0] wdata);
        @(negedge clk);
        csr_addr  = addr;
        csr_op    = op;
        csr_wdata = wdata;
        #15;
        last_rdata   = csr_rdata;
        last_illegal = illegal;
        last_target  = trap_target;
        @(negedge clk);
        csr_op = csr_pkg::CSR_NONE;
    endtask

    // a set with zero data reads without changing anything
    task automatic csr_read(input logic [11:0] addr);
        csr_access(addr, csr_pkg::CSR_SET, 32'h0);
    endtask

    `include "csr_unit_tests.svh"

    //======================================================================
    // run control
    //======================================================================
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("run stopped after %0d cycles, tests did not complete", cycle_count);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    initial begin
        seed      = 97993;
        rst_n     = 1'b0;
        csr_addr  = '0;
        csr_op    = csr_pkg::CSR_NONE;
        csr_wdata = '0;
        mvu_irq   = 1'b0;
        pc        = '0;
        cause     = '0;
        cycle_en  = 1'b0;
        mtval_model = '0;
        for (int i = 0; i < `CSR_MVU_NREGS; i++) begin
            mvu_model[i] = '0;
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        test_reset_values();
        test_read_modify_write();
        test_write_masking();
        test_illegal_and_start();
        test_cycle_counter();
        test_interrupt_return();

        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+source
+incdir+test
source/csr_pkg.sv
source/csr_access_ctrl.sv
source/machine_csr_bank.sv
source/mvu_csr_bank.sv
source/csr_unit_top.sv
test/tb_csr_unit.sv

/* Bender.yml */
package:
  name: csr_unit

sources:
  - include_dirs:
      - source
    files:
      - source/csr_pkg.sv
      - source/csr_access_ctrl.sv
      - source/machine_csr_bank.sv
      - source/mvu_csr_bank.sv
      - source/csr_unit_top.sv
  - target: test
    include_dirs:
      - source
      - test
    files:
      - test/tb_csr_unit.sv
